// ==== Bender.yml ====
package:
  name: mips_controller

sources:
  - src/ctrl_pkg.sv
  - src/decode_if.sv
  - src/alu_decoder.sv
  - src/instr_decoder.sv
  - src/cache_sequencer.sv
  - src/mips_controller.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_mips_controller.sv

// ==== mips_controller.f ====
+incdir+verification
src/ctrl_pkg.sv
src/decode_if.sv
src/alu_decoder.sv
src/instr_decoder.sv
src/cache_sequencer.sv
src/mips_controller.sv
verification/tb_mips_controller.sv

// ==== src/alu_decoder.sv ====
`timescale 1ns/1ps

module alu_decoder
    import ctrl_pkg::*;
(
    input  func_e   func,
    output alu_op_e alu_op,
    output logic    jr
);

    always_comb begin
        jr = 1'b0;
        case (func)
            F_XOR:  alu_op = ALU_XOR;
            F_SLL:  alu_op = ALU_SLL;
            F_SLLV: alu_op = ALU_SLLV;
            F_SRL:  alu_op = ALU_SRL;
            F_SRLV: alu_op = ALU_SRLV;
            F_SRA:  alu_op = ALU_SRA;
            F_ADD:  alu_op = ALU_ADD;
            F_ADDU: alu_op = ALU_ADD;  // overflow handling lives in the datapath
            F_SUB:  alu_op = ALU_SUB;
            F_SUBU: alu_op = ALU_SUB;
            F_MULT: alu_op = ALU_MULT;
            F_DIV:  alu_op = ALU_DIV;
            F_OR:   alu_op = ALU_OR;
            F_NOR:  alu_op = ALU_NOR;
            F_AND:  alu_op = ALU_AND;
            F_SLT:  alu_op = ALU_SLT;
            F_JR: begin
                alu_op = ALU_JR;
                jr     = 1'b1;
            end
            default: alu_op = ALU_ADD; // unknown func
        endcase
    end

endmodule

// ==== src/cache_sequencer.sv ====
`timescale 1ns/1ps

module cache_sequencer
    import ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    decode_if.dst         dec,
    input  logic          cache_hit,
    input  logic          cache_dirty,
    output logic          pc_enable,
    output logic          load_write,
    output logic          we_memory,
    output logic          we_cache,
    output logic          set_valid,
    output logic          set_dirty,
    output cache_src_e    cache_src,
    output mem_addr_sel_e mem_addr_sel
);

    seq_state_e            state;
    seq_state_e            next_state;
    logic [WAIT_CNT_W-1:0] wait_cnt;
    logic [WAIT_CNT_W-1:0] next_wait_cnt;
    logic                  wait_done;

    assign wait_done = (wait_cnt == WAIT_CNT_W'(MEM_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            wait_cnt <= '0;
        end else begin
            state    <= next_state;
            wait_cnt <= next_wait_cnt;
        end
    end

    // one counter shared by writeback and fetch waits
    always_comb begin
        if ((state == S_WRITEBACK || state == S_FETCH) && !wait_done) begin
            next_wait_cnt = wait_cnt + 1'b1;
        end else begin
            next_wait_cnt = '0;
        end
    end

    always_comb begin
        next_state   = state;
        pc_enable    = 1'b0;
        load_write   = 1'b0;
        we_memory    = 1'b0;
        we_cache     = 1'b0;
        set_valid    = 1'b0;
        set_dirty    = 1'b0;
        cache_src    = CACHE_SRC_CPU;
        mem_addr_sel = ADDR_ALU;

        case (state)
            S_IDLE: begin
                case (dec.mem_op)
                    MEM_LOAD: begin
                        if (cache_hit) begin
                            pc_enable  = 1'b1;
                            load_write = 1'b1;
                        end else if (cache_dirty) begin
                            // victim goes out first
                            we_memory    = 1'b1;
                            mem_addr_sel = ADDR_CACHE;
                            next_state   = S_WRITEBACK;
                        end else begin
                            next_state = S_FETCH;
                        end
                    end
                    MEM_STORE: begin
                        if (!cache_hit && cache_dirty) begin
                            we_memory    = 1'b1;
                            mem_addr_sel = ADDR_CACHE;
                            next_state   = S_WRITEBACK;
                        end else begin
                            // a whole word write lets a clean miss overwrite the line
                            we_cache  = 1'b1;
                            set_valid = 1'b1;
                            set_dirty = 1'b1;
                            pc_enable = 1'b1;
                        end
                    end
                    default: pc_enable = 1'b1;
                endcase
            end
            S_WRITEBACK: begin
                mem_addr_sel = ADDR_CACHE;
                if (wait_done) begin
                    next_state = (dec.mem_op == MEM_LOAD) ? S_FETCH : S_STORE_FILL;
                end
            end
            S_FETCH: begin
                if (wait_done) next_state = S_FILL;
            end
            S_FILL: begin
                we_cache   = 1'b1;
                set_valid  = 1'b1;
                cache_src  = CACHE_SRC_MEM; // clean line from memory
                next_state = S_COMPLETE;
            end
            S_COMPLETE: begin
                load_write = 1'b1;
                pc_enable  = 1'b1;
                next_state = S_IDLE;
            end
            S_STORE_FILL: begin
                we_cache   = 1'b1;
                set_valid  = 1'b1;
                set_dirty  = 1'b1;
                pc_enable  = 1'b1;
                next_state = S_IDLE;
            end
            default: next_state = S_IDLE;
        endcase
    end

endmodule

// ==== src/ctrl_pkg.sv ====
package ctrl_pkg;

    localparam int OPCODE_W    = 6;
    localparam int FUNC_W      = 6;
    localparam int MEM_LATENCY = 4; // wait cycles per memory transfer
    localparam int WAIT_CNT_W  = 2;

    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE = 6'b000000,
        OP_BGEZ  = 6'b000001,
        OP_J     = 6'b000010,
        OP_JAL   = 6'b000011,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_BLEZ  = 6'b000110,
        OP_BGTZ  = 6'b000111,
        OP_ADDI  = 6'b001000,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011,
        OP_NOP   = 6'b111111
    } opcode_e;

    typedef enum logic [FUNC_W-1:0] {
        F_SLL  = 6'b000000,
        F_SRL  = 6'b000010,
        F_SRA  = 6'b000011,
        F_SLLV = 6'b000100,
        F_SRLV = 6'b000110,
        F_JR   = 6'b001000,
        F_MULT = 6'b011000,
        F_DIV  = 6'b011010,
        F_ADD  = 6'b100000,
        F_ADDU = 6'b100001,
        F_SUB  = 6'b100010,
        F_SUBU = 6'b100011,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_NOR  = 6'b100111,
        F_SLT  = 6'b101010
    } func_e;

    // encodings fixed by the ALU
    typedef enum logic [4:0] {
        ALU_XOR  = 5'd0,
        ALU_SLL  = 5'd1,
        ALU_SRL  = 5'd2,
        ALU_SRA  = 5'd3,
        ALU_ADD  = 5'd4,
        ALU_SUB  = 5'd5,
        ALU_MULT = 5'd6,
        ALU_DIV  = 5'd7,
        ALU_OR   = 5'd8,
        ALU_NOR  = 5'd9,
        ALU_AND  = 5'd10,
        ALU_SLT  = 5'd11,
        ALU_JR   = 5'd12,
        ALU_BEQ  = 5'd13,
        ALU_BNE  = 5'd14,
        ALU_BLEZ = 5'd15,
        ALU_BGTZ = 5'd16,
        ALU_BGEZ = 5'd17,
        ALU_LUI  = 5'd18,
        ALU_SLLV = 5'd25,
        ALU_SRLV = 5'd26
    } alu_op_e;

    typedef enum logic [1:0] {DEST_RT = 2'd0, DEST_RD = 2'd1, DEST_RA = 2'd2} dest_sel_e;

    typedef enum logic [1:0] {SRC_ALU = 2'd0, SRC_MEM = 2'd1, SRC_PC = 2'd2} reg_src_sel_e;

    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_e;

    typedef enum logic {CACHE_SRC_MEM = 1'b0, CACHE_SRC_CPU = 1'b1} cache_src_e;

    typedef enum logic {ADDR_ALU = 1'b0, ADDR_CACHE = 1'b1} mem_addr_sel_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WRITEBACK,
        S_FETCH,
        S_FILL,
        S_COMPLETE,
        S_STORE_FILL
    } seq_state_e;

endpackage

// ==== src/decode_if.sv ====
`timescale 1ns/1ps

// decoded control from decoder to sequencer and top
interface decode_if
    import ctrl_pkg::*;
();

    alu_op_e      alu_op;
    logic         alu_src;       // 1 selects the immediate
    dest_sel_e    dest_sel;
    reg_src_sel_e reg_src;
    logic         dec_reg_write; // loads write through the sequencer
    logic         jump;
    logic         branch;
    logic         jump_register;
    logic         is_unsigned;
    logic         is_nop;
    mem_op_e      mem_op;

    modport src (
        output alu_op, alu_src, dest_sel, reg_src, dec_reg_write,
        output jump, branch, jump_register, is_unsigned, is_nop, mem_op
    );

    modport dst (
        input alu_op, alu_src, dest_sel, reg_src, dec_reg_write,
        input jump, branch, jump_register, is_unsigned, is_nop, mem_op
    );

endinterface

// ==== src/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder
    import ctrl_pkg::*;
(
    input  opcode_e     opcode,
    input  func_e       func,
    decode_if.src       dec
);

    alu_op_e r_alu_op;
    logic    r_jr;

    alu_decoder u_alu_dec (
        .func   (func),
        .alu_op (r_alu_op),
        .jr     (r_jr)
    );

    always_comb begin
        // defaults describe an instruction with no side effects
        dec.alu_op        = ALU_ADD;
        dec.alu_src       = 1'b0;
        dec.dest_sel      = DEST_RT;
        dec.reg_src       = SRC_ALU;
        dec.dec_reg_write = 1'b0;
        dec.jump          = 1'b0;
        dec.branch        = 1'b0;
        dec.jump_register = 1'b0;
        dec.is_unsigned   = 1'b0;
        dec.is_nop        = 1'b0;
        dec.mem_op        = MEM_NONE;

        case (opcode)
            OP_RTYPE: begin
                dec.dest_sel      = DEST_RD;
                dec.alu_op        = r_alu_op;
                dec.jump_register = r_jr;
                dec.dec_reg_write = 1'b1;
            end
            OP_ADDI, OP_ADDIU, OP_ANDI, OP_XORI, OP_ORI, OP_SLTI, OP_LUI: begin
                dec.alu_src       = 1'b1;
                dec.dec_reg_write = 1'b1;
                dec.is_unsigned   = (opcode != OP_ADDI) && (opcode != OP_SLTI);
                case (opcode)
                    OP_ANDI: dec.alu_op = ALU_AND;
                    OP_XORI: dec.alu_op = ALU_XOR;
                    OP_ORI:  dec.alu_op = ALU_OR;
                    OP_SLTI: dec.alu_op = ALU_SLT;
                    OP_LUI:  dec.alu_op = ALU_LUI;
                    default: dec.alu_op = ALU_ADD; // addi, addiu
                endcase
            end
            OP_LW: begin
                dec.alu_src = 1'b1;  // base plus offset
                dec.reg_src = SRC_MEM;
                dec.mem_op  = MEM_LOAD;
            end
            OP_SW: begin
                dec.alu_src = 1'b1;
                dec.mem_op  = MEM_STORE;
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BGEZ: begin
                dec.branch  = 1'b1;
                dec.alu_src = 1'b1;
                case (opcode)
                    OP_BEQ:  dec.alu_op = ALU_BEQ;
                    OP_BNE:  dec.alu_op = ALU_BNE;
                    OP_BLEZ: dec.alu_op = ALU_BLEZ;
                    OP_BGTZ: dec.alu_op = ALU_BGTZ;
                    default: dec.alu_op = ALU_BGEZ;
                endcase
            end
            OP_J: begin
                dec.jump = 1'b1;
            end
            OP_JAL: begin
                dec.jump          = 1'b1;
                dec.dest_sel      = DEST_RA; // link register
                dec.reg_src       = SRC_PC;
                dec.dec_reg_write = 1'b1;
            end
            OP_NOP: begin
                dec.is_nop = 1'b1;
            end
            default: ; // unknown opcode leaves all writes off
        endcase
    end

endmodule

// ==== src/mips_controller.sv ====
`timescale 1ns/1ps

module mips_controller
    import ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  opcode_e       opcode,
    input  func_e         func,
    input  logic          cache_hit,
    input  logic          cache_dirty,
    output dest_sel_e     dest_sel,
    output logic          jump,
    output logic          branch,
    output logic          jump_register,
    output logic          we_memory,
    output reg_src_sel_e  reg_src,
    output alu_op_e       alu_op,
    output logic          alu_src,
    output logic          register_write,
    output logic          is_unsigned,
    output logic          pc_enable,
    output logic          set_valid,
    output logic          set_dirty,
    output cache_src_e    cache_src,
    output mem_addr_sel_e mem_addr_sel,
    output logic          we_cache,
    output logic          is_nop
);

    logic load_write;

    decode_if dec_bus ();

    instr_decoder u_instr_dec (
        .opcode (opcode),
        .func   (func),
        .dec    (dec_bus)
    );

    cache_sequencer u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec          (dec_bus),
        .cache_hit    (cache_hit),
        .cache_dirty  (cache_dirty),
        .pc_enable    (pc_enable),
        .load_write   (load_write),
        .we_memory    (we_memory),
        .we_cache     (we_cache),
        .set_valid    (set_valid),
        .set_dirty    (set_dirty),
        .cache_src    (cache_src),
        .mem_addr_sel (mem_addr_sel)
    );

    assign dest_sel       = dec_bus.dest_sel;
    assign jump           = dec_bus.jump;
    assign branch         = dec_bus.branch;
    assign jump_register  = dec_bus.jump_register;
    assign reg_src        = dec_bus.reg_src;
    assign alu_op         = dec_bus.alu_op;
    assign alu_src        = dec_bus.alu_src;
    assign is_unsigned    = dec_bus.is_unsigned;
    assign is_nop         = dec_bus.is_nop;
    assign register_write = dec_bus.dec_reg_write | load_write; // loads write late

endmodule

// ==== verification/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
    logic [1:0] dest_sel;
    logic [1:0] reg_src;
    logic [4:0] alu_op;
    logic       alu_src;
    logic       reg_write;
    logic       jump;
    logic       branch;
    logic       jr;
    logic       is_unsigned;
    logic       is_nop;
} exp_dec_t;

logic [31:0] lfsr_state = 32'hc12b3e09;

// galois lfsr stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return r;
endfunction

function automatic logic [4:0] alu_op_for_func(input logic [5:0] fn);
    case (fn)
        F_XOR:          return ALU_XOR;
        F_SLL:          return ALU_SLL;
        F_SLLV:         return ALU_SLLV;
        F_SRL:          return ALU_SRL;
        F_SRLV:         return ALU_SRLV;
        F_SRA:          return ALU_SRA;
        F_SUB, F_SUBU:  return ALU_SUB;
        F_MULT:         return ALU_MULT;
        F_DIV:          return ALU_DIV;
        F_OR:           return ALU_OR;
        F_NOR:          return ALU_NOR;
        F_AND:          return ALU_AND;
        F_SLT:          return ALU_SLT;
        F_JR:           return ALU_JR;
        default:        return ALU_ADD; // add, addu and unknown codes
    endcase
endfunction

function automatic exp_dec_t imm_decode(input logic [4:0] op, input logic uns);
    exp_dec_t e;
    e             = '0;
    e.alu_op      = op;
    e.alu_src     = 1'b1;
    e.reg_write   = 1'b1;
    e.is_unsigned = uns;
    return e;
endfunction

function automatic exp_dec_t branch_decode(input logic [4:0] op);
    exp_dec_t e;
    e         = '0;
    e.alu_op  = op;
    e.alu_src = 1'b1;
    e.branch  = 1'b1;
    return e;
endfunction

function automatic exp_dec_t expected_decode(input logic [5:0] op, input logic [5:0] fn);
    exp_dec_t e;
    e        = '0;
    e.alu_op = ALU_ADD;
    case (op)
        OP_RTYPE: begin
            e.dest_sel  = DEST_RD;
            e.alu_op    = alu_op_for_func(fn);
            e.jr        = (fn == F_JR);
            e.reg_write = 1'b1;
        end
        OP_ADDI:  e = imm_decode(ALU_ADD, 1'b0);
        OP_ADDIU: e = imm_decode(ALU_ADD, 1'b1);
        OP_SLTI:  e = imm_decode(ALU_SLT, 1'b0);
        OP_ANDI:  e = imm_decode(ALU_AND, 1'b1);
        OP_ORI:   e = imm_decode(ALU_OR, 1'b1);
        OP_XORI:  e = imm_decode(ALU_XOR, 1'b1);
        OP_LUI:   e = imm_decode(ALU_LUI, 1'b1);
        OP_LW, OP_SW: begin
            e.alu_src = 1'b1;
            e.reg_src = (op == OP_LW) ? SRC_MEM : SRC_ALU; // load writes via sequencer
        end
        OP_BEQ:   e = branch_decode(ALU_BEQ);
        OP_BNE:   e = branch_decode(ALU_BNE);
        OP_BLEZ:  e = branch_decode(ALU_BLEZ);
        OP_BGTZ:  e = branch_decode(ALU_BGTZ);
        OP_BGEZ:  e = branch_decode(ALU_BGEZ);
        OP_J:     e.jump = 1'b1;
        OP_JAL: begin
            e.jump      = 1'b1;
            e.dest_sel  = DEST_RA;
            e.reg_src   = SRC_PC;
            e.reg_write = 1'b1;
        end
        OP_NOP:   e.is_nop = 1'b1;
        default:  ; // unknown opcode stays all off
    endcase
    return e;
endfunction

`endif

// ==== verification/tb_mips_controller.sv ====
`timescale 1ns/1ps

module tb_mips_controller
    import ctrl_pkg::*;
();

    localparam int NUM_RANDOM  = 48;
    localparam int NUM_MEM_OPS = 16;
    localparam int MISS_LIMIT  = 12; // longest miss is 10 cycles
    localparam int WATCHDOG_CYCLES = 4 + 2 * 64 + NUM_RANDOM + NUM_MEM_OPS * MISS_LIMIT + 16;

    logic          clk;
    logic          rst_n;
    opcode_e       opcode;
    func_e         func;
    logic          cache_hit;
    logic          cache_dirty;
    dest_sel_e     dest_sel;
    logic          jump;
    logic          branch;
    logic          jump_register;
    logic          we_memory;
    reg_src_sel_e  reg_src;
    alu_op_e       alu_op;
    logic          alu_src;
    logic          register_write;
    logic          is_unsigned;
    logic          pc_enable;
    logic          set_valid;
    logic          set_dirty;
    cache_src_e    cache_src;
    mem_addr_sel_e mem_addr_sel;
    logic          we_cache;
    logic          is_nop;

    int dec_errs   = 0;
    int seq_errs   = 0;
    int proto_errs = 0;

    `include "tb_ref_model.svh"

    mips_controller uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // victim write always uses the cache address
    assert property (@(posedge clk) disable iff (!rst_n) we_memory |-> mem_addr_sel == ADDR_CACHE)
        else begin
            proto_errs++;
            $display("we_memory was raised without the cache address selected at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        (we_cache && cache_src == CACHE_SRC_MEM) |-> (!pc_enable && !set_dirty))
        else begin
            proto_errs++;
            $display("line fill from memory released the pc or marked the line dirty at %0t",
                     $time);
        end

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act,
                             input bit in_seq);
        assert (act === exp) else begin
            if (in_seq) seq_errs++;
            else dec_errs++;
            $display("Fail %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_decode(input exp_dec_t e, input bit in_seq);
        check_val("dest_sel", e.dest_sel, dest_sel, in_seq);
        check_val("reg_src", e.reg_src, reg_src, in_seq);
        check_val("alu_op", e.alu_op, alu_op, in_seq);
        check_val("alu_src", e.alu_src, alu_src, in_seq);
        check_val("jump", e.jump, jump, in_seq);
        check_val("branch", e.branch, branch, in_seq);
        check_val("jump_register", e.jr, jump_register, in_seq);
        check_val("is_unsigned", e.is_unsigned, is_unsigned, in_seq);
        check_val("is_nop", e.is_nop, is_nop, in_seq);
    endtask

    // single cycle instruction with no memory access
    task automatic apply_decode(input logic [5:0] op, input logic [5:0] fn);
        exp_dec_t e;
        opcode = opcode_e'(op);
        func   = func_e'(fn);
        e      = expected_decode(op, fn);
        @(negedge clk);
        check_decode(e, 1'b0);
        check_val("register_write", e.reg_write, register_write, 1'b0);
        check_val("pc_enable", 1'b1, pc_enable, 1'b0);
        check_val("we_memory", 1'b0, we_memory, 1'b0);
        check_val("we_cache", 1'b0, we_cache, 1'b0);
        step_cycle();
    endtask

    task automatic run_mem_op(input bit is_store, input bit hit, input bit dirty);
        int fill_c;
        int done_c;
        int c;
        bit returned;
        bit miss_wb;
        miss_wb = !hit && dirty;
        if (!is_store) begin
            fill_c = hit ? -1 : (dirty ? MEM_LATENCY : 0) + MEM_LATENCY + 1;
            done_c = hit ? 0 : fill_c + 1;
        end else begin
            fill_c = miss_wb ? MEM_LATENCY + 1 : 0;
            done_c = fill_c;
        end
        if (is_store) opcode = OP_SW;
        else opcode = OP_LW;
        func        = F_ADD;
        cache_hit   = hit;
        cache_dirty = dirty;
        c           = 0;
        returned    = 1'b0;
        while (!returned && c < MISS_LIMIT) begin
            @(negedge clk);
            if (c == 0) check_decode(expected_decode(opcode, func), 1'b1);
            check_val("pc_enable", c == done_c, pc_enable, 1'b1);
            check_val("register_write", !is_store && c == done_c, register_write, 1'b1);
            check_val("we_memory", miss_wb && c == 0, we_memory, 1'b1);
            check_val("mem_addr_sel", miss_wb && c <= MEM_LATENCY, mem_addr_sel, 1'b1);
            check_val("we_cache", c == fill_c, we_cache, 1'b1);
            check_val("set_valid", c == fill_c, set_valid, 1'b1);
            check_val("set_dirty", is_store && c == fill_c, set_dirty, 1'b1);
            if (c == fill_c) begin
                check_val("cache_src", is_store ? CACHE_SRC_CPU : CACHE_SRC_MEM, cache_src, 1'b1);
            end
            returned = pc_enable;
            c++;
            step_cycle();
            if (!returned) begin
                cache_hit   = 1'(rand_bits(1)); // must be ignored outside idle
                cache_dirty = 1'(rand_bits(1));
            end
        end
        if (!returned) begin
            proto_errs++;
            $display("pc_enable never returned (store %0d hit %0d dirty %0d)",
                     is_store, hit, dirty);
        end
        opcode      = OP_NOP;
        cache_hit   = 1'b0;
        cache_dirty = 1'b0;
    endtask

    initial begin
        logic [5:0] rnd_op;
        rst_n       = 1'b0;
        opcode      = OP_NOP;
        func        = F_ADD;
        cache_hit   = 1'b0;
        cache_dirty = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        @(negedge clk);
        check_val("we_memory", 1'b0, we_memory, 1'b1);
        check_val("we_cache", 1'b0, we_cache, 1'b1);
        check_val("set_valid", 1'b0, set_valid, 1'b1);
        check_val("set_dirty", 1'b0, set_dirty, 1'b1);
        check_val("mem_addr_sel", ADDR_ALU, mem_addr_sel, 1'b1);
        step_cycle();

        for (int op = 0; op < 64; op++) begin
            if (op != OP_LW && op != OP_SW) apply_decode(6'(op), 6'(rand_bits(6)));
        end
        for (int fn = 0; fn < 64; fn++) apply_decode(OP_RTYPE, 6'(fn));
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd_op = 6'(rand_bits(6));
            if (rnd_op == OP_LW || rnd_op == OP_SW) rnd_op = OP_RTYPE;
            apply_decode(rnd_op, 6'(rand_bits(6)));
        end

        // all hit and dirty cases then random ones
        for (int k = 0; k < 8; k++) run_mem_op(k[2], k[1], k[0]);
        for (int k = 0; k < NUM_MEM_OPS - 8; k++) begin
            run_mem_op(1'(rand_bits(1)), 1'(rand_bits(1)), 1'(rand_bits(1)));
        end

        $display("errors: decode %0d, sequence %0d, protocol %0d",
                 dec_errs, seq_errs, proto_errs);
        if (dec_errs + seq_errs + proto_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule
